// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_his_top
RTL_TOP   ?= his_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/histo_pkg.sv
package histo_pkg;

    // histogram geometry
    // time bins per pixel
    localparam int BIN_NUM   = 16;
    localparam int BIN_W     = 4;
    // pixels per acquisition
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W   = 2;
    // events per pixel in one acquisition
    localparam int DATA_NUM  = 4;
    // acquisitions folded into one histogram
    localparam int ACQ_NUM   = 3;

    // sequencer counter widths
    localparam int DATA_CNT_W = 2;
    localparam int ACQ_CNT_W  = 2;

    // bin counter, small so that saturation shows up quickly
    localparam int COUNT_W  = 3;
    // cell address is {pixel, bin}
    localparam int CELL_W   = PIXEL_W + BIN_W;
    localparam int CELL_NUM = PIXEL_NUM * BIN_NUM;

    // completed histogram counter in the status word
    localparam int DONE_CNT_W = 8;

    // axi4-lite widths
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;

    // register map, byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS  = 12'h000;
    localparam logic [AXI_ADDR_W-1:0] REG_CONTROL = 12'h004;
    // histogram window, one word per cell
    localparam logic [AXI_ADDR_W-1:0] HIST_BASE   = 12'h100;

    // host read channel
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_RESP
    } rd_state_t;

endpackage

// File: hdl/axil_his_readout.sv
`timescale 1ns/1ps

module axil_his_readout import histo_pkg::*; (
    input  logic                    clk,
    input  logic                    res,
    // axi4-lite slave
    input  logic [AXI_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [AXI_DATA_W-1:0]   s_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [AXI_ADDR_W-1:0]   s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [AXI_DATA_W-1:0]   s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    // builder side
    input  logic                    his_done,
    input  logic                    done_bank,
    output logic                    enable,
    output logic                    bank_busy,
    // bank port b
    output logic                    b_rd_en,
    output logic                    b_bank,
    output logic [CELL_W-1:0]       b_cell,
    input  logic [COUNT_W-1:0]      b_rd_data,
    output logic                    b_clr
);

    rd_state_t               rd_state;
    logic                    his_ready;
    logic                    ready_bank;
    logic [DONE_CNT_W-1:0]   his_count;
    logic                    ctrl_wr;
    logic                    release_hit;
    logic                    ar_hit;
    logic                    ar_hit_q;
    logic                    ar_status_q;
    logic [AXI_DATA_W-1:0]   status_word;

    // always OKAY
    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    // write side, address and data taken together
    assign s_wready    = s_awready;
    assign ctrl_wr     = s_awready && (s_awaddr == REG_CONTROL) && s_wstrb[0];
    assign release_hit = ctrl_wr && s_wdata[1];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s_awready <= 1'b0;
            s_bvalid  <= 1'b0;
            enable    <= 1'b0;
        end else begin
            s_awready <= 1'b0;
            if (s_awready) begin
                s_bvalid <= 1'b1;
            end else if (s_awvalid && s_wvalid && !s_bvalid) begin
                s_awready <= 1'b1;
            end
            if (s_bvalid && s_bready) begin
                s_bvalid <= 1'b0;
            end
            if (ctrl_wr) begin
                enable <= s_wdata[0];
            end
        end
    end

    // finished bank handed to the host until release
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            his_ready  <= 1'b0;
            ready_bank <= 1'b0;
            his_count  <= '0;
        end else if (his_done) begin
            his_ready  <= 1'b1;
            ready_bank <= done_bank;
            his_count  <= his_count + 1'b1;
        end else if (release_hit) begin
            his_ready <= 1'b0;
        end
    end

    assign bank_busy   = his_ready;
    assign status_word = {16'd0, his_count, 6'd0, ready_bank, his_ready};

    // histogram window decode, cell index from the word address
    assign ar_hit  = (s_araddr[AXI_ADDR_W-1:CELL_W+2] == HIST_BASE[AXI_ADDR_W-1:CELL_W+2]);
    assign b_rd_en = s_arready && s_arvalid && ar_hit;
    assign b_cell  = s_araddr[CELL_W+1:2];
    assign b_bank  = ready_bank;
    // clear the cell one cycle after its read
    assign b_clr   = (rd_state == RD_MEM) && ar_hit_q;

    assign s_rvalid = (rd_state == RD_RESP);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_state  <= RD_IDLE;
            s_arready <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (s_arready && s_arvalid) begin
                        s_arready <= 1'b0;
                        rd_state  <= RD_MEM;
                    end else begin
                        s_arready <= 1'b1;
                    end
                end
                // bank data arrives here
                RD_MEM: begin
                    rd_state <= RD_RESP;
                end
                // hold until the host takes it
                RD_RESP: begin
                    if (s_rready) begin
                        s_arready <= 1'b1;
                        rd_state  <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // read payload
    always_ff @(posedge clk) begin
        if (s_arready && s_arvalid) begin
            ar_hit_q    <= ar_hit;
            ar_status_q <= (s_araddr == REG_STATUS);
        end
        if (rd_state == RD_MEM) begin
            if (ar_hit_q) begin
                s_rdata <= AXI_DATA_W'(b_rd_data);
            end else if (ar_status_q) begin
                s_rdata <= status_word;
            end else begin
                s_rdata <= '0;
            end
        end
    end

endmodule

// File: hdl/his_bank_pair.sv
`timescale 1ns/1ps

module his_bank_pair import histo_pkg::*; (
    input  logic               clk,
    input  logic               res,
    // port a, build side
    input  logic               rd_en,
    input  logic               rd_bank,
    input  logic [CELL_W-1:0]  rd_cell,
    output logic [COUNT_W-1:0] rd_data,
    input  logic               wr_en,
    input  logic               wr_bank,
    input  logic [CELL_W-1:0]  wr_cell,
    input  logic [COUNT_W-1:0] wr_data,
    // port b, host side
    input  logic               b_rd_en,
    input  logic               b_bank,
    input  logic [CELL_W-1:0]  b_cell,
    output logic [COUNT_W-1:0] b_rd_data,
    input  logic               b_clr
);

    // one array of counters per bank
    logic [COUNT_W-1:0] mem [2][CELL_NUM];
    // cell last read on port b, target of the clear
    logic               clr_bank;
    logic [CELL_W-1:0]  clr_cell;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int c = 0; c < CELL_NUM; c++) begin
                    mem[b][c] <= '0;
                end
            end
            rd_data   <= '0;
            b_rd_data <= '0;
            clr_bank  <= 1'b0;
            clr_cell  <= '0;
        end else begin
            // one cycle reads, old data on a same edge write
            if (rd_en) begin
                rd_data <= mem[rd_bank][rd_cell];
            end
            if (b_rd_en) begin
                b_rd_data <= mem[b_bank][b_cell];
                clr_bank  <= b_bank;
                clr_cell  <= b_cell;
            end
            if (wr_en) begin
                mem[wr_bank][wr_cell] <= wr_data;
            end
            // host clear, the two ports normally work on different banks
            if (b_clr) begin
                mem[clr_bank][clr_cell] <= '0;
            end
        end
    end

endmodule

// File: hdl/his_top.sv
`timescale 1ns/1ps

module his_top import histo_pkg::*; (
    input  logic                    clk,
    input  logic                    res,
    // detector event stream
    input  logic                    evt_valid,
    input  logic [BIN_W-1:0]        evt_bin,
    output logic                    evt_ready,
    // host
    input  logic [AXI_ADDR_W-1:0]   s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [AXI_DATA_W-1:0]   s_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [AXI_ADDR_W-1:0]   s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [AXI_DATA_W-1:0]   s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready
);

    // sequencer to accumulator
    logic               acc_valid;
    logic [CELL_W-1:0]  acc_cell;
    logic               acc_bank;
    logic               acc_last;
    // accumulator to bank port a
    logic               rd_en;
    logic               rd_bank;
    logic [CELL_W-1:0]  rd_cell;
    logic [COUNT_W-1:0] rd_data;
    logic               wr_en;
    logic               wr_bank;
    logic [CELL_W-1:0]  wr_cell;
    logic [COUNT_W-1:0] wr_data;
    // completion and ownership
    logic               his_done;
    logic               done_bank;
    logic               enable;
    logic               bank_busy;
    // readout to bank port b
    logic               b_rd_en;
    logic               b_bank;
    logic [CELL_W-1:0]  b_cell;
    logic [COUNT_W-1:0] b_rd_data;
    logic               b_clr;

    his_sequencer his_sequencer_inst (
        .clk       (clk),
        .res       (res),
        .enable    (enable),
        .evt_valid (evt_valid),
        .evt_bin   (evt_bin),
        .evt_ready (evt_ready),
        .bank_busy (bank_busy),
        .acc_valid (acc_valid),
        .acc_cell  (acc_cell),
        .acc_bank  (acc_bank),
        .acc_last  (acc_last)
    );

    his_accumulator his_accumulator_inst (
        .clk       (clk),
        .res       (res),
        .acc_valid (acc_valid),
        .acc_cell  (acc_cell),
        .acc_bank  (acc_bank),
        .acc_last  (acc_last),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_cell   (rd_cell),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_cell   (wr_cell),
        .wr_data   (wr_data),
        .his_done  (his_done),
        .done_bank (done_bank)
    );

    his_bank_pair his_bank_pair_inst (
        .clk       (clk),
        .res       (res),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_cell   (rd_cell),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_cell   (wr_cell),
        .wr_data   (wr_data),
        .b_rd_en   (b_rd_en),
        .b_bank    (b_bank),
        .b_cell    (b_cell),
        .b_rd_data (b_rd_data),
        .b_clr     (b_clr)
    );

    axil_his_readout axil_his_readout_inst (
        .clk       (clk),
        .res       (res),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .his_done  (his_done),
        .done_bank (done_bank),
        .enable    (enable),
        .bank_busy (bank_busy),
        .b_rd_en   (b_rd_en),
        .b_bank    (b_bank),
        .b_cell    (b_cell),
        .b_rd_data (b_rd_data),
        .b_clr     (b_clr)
    );

endmodule

// File: his_builder/his_accumulator.sv
`timescale 1ns/1ps

module his_accumulator import histo_pkg::*; (
    input  logic               clk,
    input  logic               res,
    input  logic               acc_valid,
    input  logic [CELL_W-1:0]  acc_cell,
    input  logic               acc_bank,
    input  logic               acc_last,
    output logic               rd_en,
    output logic               rd_bank,
    output logic [CELL_W-1:0]  rd_cell,
    input  logic [COUNT_W-1:0] rd_data,
    output logic               wr_en,
    output logic               wr_bank,
    output logic [CELL_W-1:0]  wr_cell,
    output logic [COUNT_W-1:0] wr_data,
    output logic               his_done,
    output logic               done_bank
);

    logic               s2_valid;
    logic               s2_last;
    logic               s2_bank;
    logic [CELL_W-1:0]  s2_cell;
    logic               fwd_hit;
    logic [COUNT_W-1:0] fwd_data;
    logic [COUNT_W-1:0] cur_count;

    // stage 1, read request issued in the accept cycle
    assign rd_en   = acc_valid;
    assign rd_bank = acc_bank;
    assign rd_cell = acc_cell;

    // stage 1 to stage 2 tag, control part
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2_valid  <= 1'b0;
            s2_last   <= 1'b0;
            fwd_hit   <= 1'b0;
            his_done  <= 1'b0;
            done_bank <= 1'b0;
        end else begin
            s2_valid <= acc_valid;
            s2_last  <= acc_valid && acc_last;
            // read and write of the same cell meet on one edge
            // memory returns the old count then
            fwd_hit  <= acc_valid && s2_valid
                        && (acc_cell == s2_cell) && (acc_bank == s2_bank);
            // completion one cycle after the final write
            his_done <= s2_valid && s2_last;
            if (s2_valid && s2_last) begin
                done_bank <= s2_bank;
            end
        end
    end

    // event tag and forwarded value
    always_ff @(posedge clk) begin
        s2_cell  <= acc_cell;
        s2_bank  <= acc_bank;
        fwd_data <= wr_data;
    end

    // stage 2, pick memory data or the value just written
    assign cur_count = fwd_hit ? fwd_data : rd_data;

    // saturating increment, all ones sticks
    assign wr_data = (&cur_count) ? cur_count : cur_count + 1'b1;

    assign wr_en   = s2_valid;
    assign wr_bank = s2_bank;
    assign wr_cell = s2_cell;

endmodule

// File: his_builder/his_sequencer.sv
`timescale 1ns/1ps

module his_sequencer import histo_pkg::*; (
    input  logic              clk,
    input  logic              res,
    input  logic              enable,
    input  logic              evt_valid,
    input  logic [BIN_W-1:0]  evt_bin,
    output logic              evt_ready,
    input  logic              bank_busy,
    output logic              acc_valid,
    output logic [CELL_W-1:0] acc_cell,
    output logic              acc_bank,
    output logic              acc_last
);

    logic [DATA_CNT_W-1:0] evt_cnt;
    logic [PIXEL_W-1:0]    pix_cnt;
    logic [ACQ_CNT_W-1:0]  acq_cnt;
    logic                  build_bank;
    logic                  last_evt;
    logic                  last_pix;
    logic                  last_acq;
    logic                  his_start;
    logic                  accept;

    // wrap points of the three nested counters
    assign last_evt = (evt_cnt == DATA_CNT_W'(DATA_NUM - 1));
    assign last_pix = (pix_cnt == PIXEL_W'(PIXEL_NUM - 1));
    assign last_acq = (acq_cnt == ACQ_CNT_W'(ACQ_NUM - 1));

    // all counters at zero, next event opens a histogram
    assign his_start = (evt_cnt == '0) && (pix_cnt == '0) && (acq_cnt == '0);

    // hold off a new histogram while the host still owns a finished bank
    assign evt_ready = enable && !(his_start && bank_busy);
    assign accept    = evt_valid && evt_ready;

    // accepted event goes straight to the accumulator
    assign acc_valid = accept;
    assign acc_cell  = {pix_cnt, evt_bin};
    assign acc_bank  = build_bank;
    assign acc_last  = accept && last_evt && last_pix && last_acq;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evt_cnt    <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            build_bank <= 1'b0;
        end else if (accept) begin
            if (!last_evt) begin
                evt_cnt <= evt_cnt + 1'b1;
            end else begin
                // pixel done
                evt_cnt <= '0;
                if (!last_pix) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    // acquisition done
                    pix_cnt <= '0;
                    if (!last_acq) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        // histogram done, switch to the other bank
                        acq_cnt    <= '0;
                        build_bank <= ~build_bank;
                    end
                end
            end
        end
    end

endmodule

// File: sources.f
+incdir+tests
common/histo_pkg.sv
his_builder/his_sequencer.sv
his_builder/his_accumulator.sv
hdl/his_bank_pair.sv
hdl/axil_his_readout.sv
hdl/his_top.sv
tests/tb_his_top.sv

// File: tests/his_tb_tasks.svh
// one lcg step per generated bin
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// single axi4-lite write
// entered and left 1 ns after a rising edge
task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr,
                          input logic [AXI_DATA_W-1:0] data);
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = '1;
    s_wvalid  = 1'b1;
    // address and data go in on the same edge
    while (!s_awready) begin
        @(posedge clk);
        #1;
    end
    check_value("s_wready", 32'(s_wready), 32'h1);
    @(posedge clk);
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    while (!s_bvalid) begin
        @(posedge clk);
        #1;
    end
    check_value("s_bresp", 32'(s_bresp), 32'h0);
    @(posedge clk);
    #1;
    s_bready = 1'b0;
endtask

// single axi4-lite read with the same edge timing as the write
task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr,
                         output logic [AXI_DATA_W-1:0] data);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    while (!s_arready) begin
        @(posedge clk);
        #1;
    end
    @(posedge clk);
    #1;
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    // response held until taken
    while (!s_rvalid) begin
        @(posedge clk);
        #1;
    end
    data = s_rdata;
    check_value("s_rresp", 32'(s_rresp), 32'h0);
    @(posedge clk);
    #1;
    s_rready = 1'b0;
endtask

// one detector event with evt_valid left high for back to back use
task automatic drive_event(input logic [BIN_W-1:0] bin);
    evt_valid = 1'b1;
    evt_bin   = bin;
    while (!evt_ready) begin
        @(posedge clk);
        #1;
    end
    // accepted on this edge
    @(posedge clk);
    #1;
endtask

// File: tests/tb_his_top.sv
`timescale 1ns/1ps

module tb_his_top import histo_pkg::*; ();

    localparam int HIS_EVENTS   = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int TOTAL_EVENTS = 3 * HIS_EVENTS;
    localparam int CYCLE_LIMIT  = 4 * TOTAL_EVENTS + 2000;
    localparam int COUNT_MAX    = (1 << COUNT_W) - 1;

    logic                    clk = 1'b0;
    logic                    res;
    logic                    evt_valid;
    logic [BIN_W-1:0]        evt_bin;
    logic                    evt_ready;
    logic [AXI_ADDR_W-1:0]   s_awaddr;
    logic                    s_awvalid;
    logic                    s_awready;
    logic [AXI_DATA_W-1:0]   s_wdata;
    logic [AXI_DATA_W/8-1:0] s_wstrb;
    logic                    s_wvalid;
    logic                    s_wready;
    logic [1:0]              s_bresp;
    logic                    s_bvalid;
    logic                    s_bready;
    logic [AXI_ADDR_W-1:0]   s_araddr;
    logic                    s_arvalid;
    logic                    s_arready;
    logic [AXI_DATA_W-1:0]   s_rdata;
    logic [1:0]              s_rresp;
    logic                    s_rvalid;
    logic                    s_rready;

    int errors       = 0;
    int prop_errors  = 0;
    int checks       = 0;
    int tests_run    = 0;
    int err_mark     = 0;
    int evt_accepted = 0;
    int cycles       = 0;
    // expected counts of the bank being built
    int model [PIXEL_NUM][BIN_NUM];
    logic [31:0] lcg_state;
    logic [AXI_DATA_W-1:0] status;

    his_top his_top_inst (.*);

    // 8 ns clock
    always #4 clk = ~clk;

    // accepted events counted on the edge that takes them
    always @(posedge clk) begin
        if (res && evt_valid && evt_ready) begin
            evt_accepted <= evt_accepted + 1;
        end
    end

    // new read address only once the response is gone
    assert property (@(posedge clk) disable iff (!res) s_rvalid |-> !s_arready)
        else begin
            $display("read address accepted while a read response was pending");
            prop_errors++;
        end

    // one write in flight
    assert property (@(posedge clk) disable iff (!res) s_bvalid |-> !s_awready)
        else begin
            $display("write address accepted while a write response was pending");
            prop_errors++;
        end

    `include "his_tb_tasks.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors + prop_errors - err_mark);
        err_mark = errors + prop_errors;
    endtask

    function automatic logic [AXI_ADDR_W-1:0] cell_addr(input int p, input int b);
        return AXI_ADDR_W'(int'(HIST_BASE) + 4 * (p * BIN_NUM + b));
    endfunction

    // status word from the register map
    function automatic logic [31:0] expected_status(input int count, input int bank,
                                                    input int ready);
        return (32'(count % 256) << 8) | (32'(bank) << 1) | 32'(ready);
    endfunction

    task automatic clear_model();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                model[p][b] = 0;
            end
        end
    endtask

    // one full histogram from event index first on
    task automatic drive_histogram(input int first, input bit random_bins,
                                   input logic [BIN_W-1:0] fixed_bin);
        logic [BIN_W-1:0] bin;
        int pix;
        for (int i = first; i < HIS_EVENTS; i++) begin
            bin = fixed_bin;
            if (random_bins) begin
                lcg_state = lcg_next(lcg_state);
                bin = lcg_state[19:16];
            end
            // pixel follows event order with DATA_NUM events each
            pix = (i / DATA_NUM) % PIXEL_NUM;
            if (model[pix][bin] < COUNT_MAX) begin
                model[pix][bin]++;
            end
            drive_event(bin);
        end
        evt_valid = 1'b0;
    endtask

    // poll STATUS until a bank is handed over
    task automatic wait_ready(output logic [AXI_DATA_W-1:0] word);
        axil_read(REG_STATUS, word);
        while (!word[0]) begin
            axil_read(REG_STATUS, word);
        end
    endtask

    // every cell of the ready bank against the model or zero
    task automatic check_bank(input bit expect_zero);
        logic [AXI_DATA_W-1:0] data;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                axil_read(cell_addr(p, b), data);
                check_value($sformatf("s_rdata p%0d b%0d", p, b), data,
                            expect_zero ? 32'h0 : 32'(model[p][b]));
            end
        end
    endtask

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        res       = 1'b0;
        evt_valid = 1'b0;
        evt_bin   = '0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        lcg_state = 32'haab5;
        clear_model();
        repeat (10) @(posedge clk);
        #1;
        res = 1'b1;

        // idle outputs and the enable bit
        check_value("evt_ready", 32'(evt_ready), 32'h0);
        check_value("his_ready", 32'(his_top_inst.axil_his_readout_inst.his_ready), 32'h0);
        check_value("s_bvalid", 32'(s_bvalid), 32'h0);
        check_value("s_rvalid", 32'(s_rvalid), 32'h0);
        axil_read(REG_STATUS, status);
        check_value("status", status, 32'h0);
        axil_write(REG_CONTROL, 32'h1);
        check_value("evt_ready", 32'(evt_ready), 32'h1);
        finish_test("reset state");

        // random bins into bank 0
        drive_histogram(0, 1'b1, '0);
        wait_ready(status);
        check_value("status", status, expected_status(1, 0, 1));
        check_bank(1'b0);
        finish_test("histogram content");

        // second read of each cell before the release
        check_bank(1'b1);
        axil_write(REG_CONTROL, 32'h3);
        axil_read(REG_STATUS, status);
        check_value("status", status, expected_status(1, 0, 0));
        finish_test("read and clear");

        // same bin back to back for forwarding and saturation
        clear_model();
        drive_histogram(0, 1'b0, 4'h5);
        wait_ready(status);
        check_value("status", status, expected_status(2, 1, 1));
        check_bank(1'b0);
        finish_test("saturation and forwarding");

        // next histogram waits while the host still owns bank 1
        clear_model();
        evt_bin   = 4'h3;
        evt_valid = 1'b1;
        repeat (16) begin
            check_value("evt_ready", 32'(evt_ready), 32'h0);
            @(posedge clk);
            #1;
        end
        check_value("evt_accepted", evt_accepted, 2 * HIS_EVENTS);
        axil_write(REG_CONTROL, 32'h3);
        while (evt_accepted == 2 * HIS_EVENTS) begin
            @(posedge clk);
            #1;
        end
        evt_valid   = 1'b0;
        model[0][3] = 1;
        drive_histogram(1, 1'b1, '0);
        finish_test("stall and release");

        // third histogram lands in bank 0 again
        wait_ready(status);
        check_value("status", status, expected_status(3, 0, 1));
        check_bank(1'b0);
        finish_test("bank and count status");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks,
                 errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
